//--- src/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

	//------------------------------------------------------------
	// widths
	//------------------------------------------------------------
	typedef logic [15:0] sample_t;		// one payload word
	typedef logic [7:0]  byte_t;		// one byte on the serial line

	// mode byte expected by the pc viewer, 1 = image stream
	localparam byte_t FRAME_MODE = 8'h01;

	//------------------------------------------------------------
	// fsm encodings
	//------------------------------------------------------------
	typedef enum logic [2:0] {
		S_IDLE,			// wait for a word in the fifo
		S_HEADER,		// load mode / ~mode
		S_FETCH,		// one rd handshake
		S_TRAILER,		// load ~mode / mode
		S_SEND			// two bytes to the uart
	} sender_state_t;

	typedef enum logic [1:0] {
		C_WAIT_IN,		// idle, waiting on in_req
		C_PUSH,			// write handshake with the fifo
		C_RELEASE		// in_ack high until in_req drops
	} capture_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

`default_nettype wire

//--- src/word_if.sv
`timescale 1ns/1ps
`default_nettype none

interface word_if;
	import uart_frame_pkg::*;

	logic		req;		// requester -> responder
	logic		ack;		// responder -> requester
	logic		ready;		// fifo has space (wr) or holds a word (rd)
	wire sample_t	data;		// owned by the side that carries the payload

	// write side: requester drives data
	// read side: responder drives data
	modport requester (
		output	req,
		input	ack,
		input	ready,
		inout	data
	);

	modport responder (
		input	req,
		output	ack,
		output	ready,
		inout	data
	);

endinterface

`default_nettype wire

//--- src/word_capture.sv
`timescale 1ns/1ps
`default_nettype none

module word_capture (
	input  wire				SYS_CLK,
	input  wire				RST_N,
	input  wire				in_req,
	output logic				in_ack,
	input  wire uart_frame_pkg::sample_t	in_data,
	word_if.requester			wr
);
	import uart_frame_pkg::*;

	capture_state_t	state;
	sample_t	word_q;			// stable for the whole wr handshake

	assign wr.data = word_q;

	// payload taken on the in_req edge seen in C_WAIT_IN
	always_ff @(posedge SYS_CLK) begin
		if (state == C_WAIT_IN && in_req) begin
			word_q <= in_data;
		end
	end

	//------------------------------------------------------------
	// handshake fsm
	//------------------------------------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state  <= C_WAIT_IN;
			in_ack <= 1'b0;
			wr.req <= 1'b0;
		end else begin
			case (state)
				C_WAIT_IN: begin
					if (in_req) begin		// new word from outside
						state <= C_PUSH;
					end
				end
				C_PUSH: begin
					if (wr.req && wr.ack) begin	// word is in the fifo
						wr.req <= 1'b0;
						in_ack <= 1'b1;
						state  <= C_RELEASE;
					end else if (!wr.req && !wr.ack && wr.ready) begin
						wr.req <= 1'b1;		// full fifo stalls here
					end
				end
				C_RELEASE: begin
					if (!in_req) begin		// source done so phase 4 closes
						in_ack <= 1'b0;
						state  <= C_WAIT_IN;
					end
				end
				default: state <= C_WAIT_IN;
			endcase
		end
	end

	// rule 1 of the four-phase link
	a_wr_req_ready: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		$rose(wr.req) |-> wr.ready);

endmodule

`default_nettype wire

//--- src/word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
	parameter int FIFO_DEPTH = 8		// power of two
) (
	input  wire		SYS_CLK,
	input  wire		RST_N,
	word_if.responder	wr,
	word_if.responder	rd
);
	import uart_frame_pkg::*;

	localparam int		AW       = $clog2(FIFO_DEPTH);
	localparam logic [AW:0]	FULL_CNT = (AW + 1)'(FIFO_DEPTH);

	sample_t	mem [FIFO_DEPTH];
	logic [AW-1:0]	wr_ptr;			// wraps on its own
	logic [AW-1:0]	rd_ptr;
	logic [AW:0]	count;			// words stored
	sample_t	rd_q;			// read word, valid while rd.ack
	logic		wr_do;
	logic		rd_do;

	assign wr.ready = (count != FULL_CNT);
	assign rd.ready = (count != '0);
	assign rd.data  = rd_q;

	// the transfer happens on the req edge, before ack goes up
	assign wr_do = wr.req && !wr.ack;
	assign rd_do = rd.req && !rd.ack;

	//------------------------------------------------------------
	// write port
	//------------------------------------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr.ack <= 1'b0;
			wr_ptr <= '0;
		end else begin
			if (wr_do) begin
				wr.ack <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
			end else if (!wr.req) begin
				wr.ack <= 1'b0;		// one cycle after req falls
			end
		end
	end

	//------------------------------------------------------------
	// read port
	//------------------------------------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd.ack <= 1'b0;
			rd_ptr <= '0;
		end else begin
			if (rd_do) begin
				rd.ack <= 1'b1;
				rd_ptr <= rd_ptr + 1'b1;
			end else if (!rd.req) begin
				rd.ack <= 1'b0;
			end
		end
	end

	// fill level, both ports may fire in one cycle
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			count <= '0;
		end else begin
			count <= count + {{AW{1'b0}}, wr_do} - {{AW{1'b0}}, rd_do};
		end
	end

	// storage
	always_ff @(posedge SYS_CLK) begin
		if (wr_do) begin
			mem[wr_ptr] <= wr.data;
		end
		if (rd_do) begin
			rd_q <= mem[rd_ptr];
		end
	end

	a_no_write_full: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		wr_do |-> (count != FULL_CNT));

	a_no_read_empty: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		rd_do |-> (count != '0));

endmodule

`default_nettype wire

//--- src/frame_sender.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sender #(
	parameter int FRAME_WORDS = 4		// payload words per frame
) (
	input  wire				SYS_CLK,
	input  wire				RST_N,
	word_if.requester			rd,
	output uart_frame_pkg::byte_t		tx_data,
	output logic				tx_req,
	input  wire				tx_busy
);
	import uart_frame_pkg::*;

	localparam int			CW        = $clog2(FRAME_WORDS + 1);
	localparam logic [CW-1:0]	LAST_WORD = CW'(FRAME_WORDS);

	sender_state_t	state;
	sample_t	send_data;		// byte pair with [7:0] going out first
	logic [2:0]	step;			// position in the two-byte sequence
	logic [CW-1:0]	word_cnt;		// payload words sent this frame
	logic		trailer_sent;		// current pair closes the frame

	//------------------------------------------------------------
	// byte pair to send
	//------------------------------------------------------------
	always_ff @(posedge SYS_CLK) begin
		case (state)
			S_HEADER:  send_data <= {~FRAME_MODE, FRAME_MODE};	// 01 then fe
			S_TRAILER: send_data <= {FRAME_MODE, ~FRAME_MODE};	// fe then 01
			S_FETCH: begin
				if (rd.req && rd.ack) begin
					send_data <= rd.data;	// valid while ack high
				end
			end
			default: ;
		endcase
	end

	//------------------------------------------------------------
	// frame fsm
	//------------------------------------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state        <= S_IDLE;
			step         <= 3'd0;
			word_cnt     <= '0;
			trailer_sent <= 1'b0;
			rd.req       <= 1'b0;
			tx_req       <= 1'b0;
			tx_data      <= 8'hff;
		end else begin
			case (state)
				S_IDLE: begin
					if (rd.ready) begin		// fifo holds a word
						state <= S_HEADER;
					end
				end
				S_HEADER: begin
					word_cnt     <= '0;
					trailer_sent <= 1'b0;
					step         <= 3'd0;
					state        <= S_SEND;
				end
				S_FETCH: begin
					if (rd.req && rd.ack) begin
						rd.req   <= 1'b0;
						word_cnt <= word_cnt + 1'b1;
						step     <= 3'd0;
						state    <= S_SEND;
					end else if (!rd.req && !rd.ack && rd.ready) begin
						rd.req <= 1'b1;		// waits here while fifo empty
					end
				end
				S_TRAILER: begin
					trailer_sent <= 1'b1;
					step         <= 3'd0;
					state        <= S_SEND;
				end
				S_SEND: begin
					case (step)
						3'd0: begin
							if (!tx_busy) begin
								tx_data <= send_data[7:0];
								tx_req  <= 1'b1;
								step    <= 3'd1;
							end
						end
						3'd1: begin
							if (tx_busy) begin	// low byte latched
								tx_data <= send_data[15:8];
								step    <= 3'd2;
							end
						end
						3'd2: begin
							if (!tx_busy) begin	// uart picks up high byte next
								step <= 3'd3;
							end
						end
						3'd3: begin
							if (tx_busy) begin
								tx_req <= 1'b0;
								step   <= 3'd4;
							end
						end
						3'd4: begin
							if (!tx_busy) begin	// pair done
								step <= 3'd0;
								if (trailer_sent) begin
									state <= S_IDLE;
								end else if (word_cnt == LAST_WORD) begin
									state <= S_TRAILER;
								end else begin
									state <= S_FETCH;
								end
							end
						end
						default: step <= 3'd0;
					endcase
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// uart still busy with the second byte when req drops
	a_req_held: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		$fell(tx_req) |-> tx_busy);

	a_rd_req_ready: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		$rose(rd.req) |-> rd.ready);

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 8		// SYS_CLK cycles per bit
) (
	input  wire				SYS_CLK,
	input  wire				RST_N,
	input  wire				tx_req,
	input  wire uart_frame_pkg::byte_t	tx_data,
	output logic				tx_busy,
	output logic				txd
);
	import uart_frame_pkg::*;

	localparam int			CW       = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CW-1:0]	BIT_LAST = CW'(CLKS_PER_BIT - 1);

	tx_state_t	state;
	logic [CW-1:0]	clk_cnt;		// position inside one bit
	logic [2:0]	bit_idx;		// data bit on the line
	byte_t		shreg;			// lsb is next out
	logic		bit_end;

	assign bit_end = (clk_cnt == BIT_LAST);

	// bit period counter, held at 0 while idle
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			clk_cnt <= '0;
		end else if (state == TX_IDLE || bit_end) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	always_ff @(posedge SYS_CLK) begin
		if (state == TX_IDLE && tx_req) begin
			shreg <= tx_data;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shreg <= {1'b0, shreg[7:1]};
		end
	end

	//------------------------------------------------------------
	// line fsm, start + 8 data + stop
	//------------------------------------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state   <= TX_IDLE;
			bit_idx <= 3'd0;
			tx_busy <= 1'b0;
			txd     <= 1'b1;		// line idles high
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_req) begin
						tx_busy <= 1'b1;
						txd     <= 1'b0;	// start bit
						state   <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						txd     <= shreg[0];
						bit_idx <= 3'd0;
						state   <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							txd   <= 1'b1;	// stop bit
							state <= TX_STOP;
						end else begin
							txd     <= shreg[0];
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin	// busy low at least one cycle
						tx_busy <= 1'b0;
						state   <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	a_idle_high: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		!tx_busy |-> txd);

endmodule

`default_nettype wire

//--- src/uart_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_frame_top #(
	parameter int FRAME_WORDS  = 4,
	parameter int FIFO_DEPTH   = 8,
	parameter int CLKS_PER_BIT = 8
) (
	input  wire				SYS_CLK,
	input  wire				RST_N,
	input  wire				in_req,
	output wire				in_ack,
	input  wire uart_frame_pkg::sample_t	in_data,
	output wire				txd
);
	import uart_frame_pkg::*;

	//------------------------------------------------------------
	// internal links
	//------------------------------------------------------------
	word_if wr_link ();			// capture -> fifo
	word_if rd_link ();			// fifo -> sender

	wire byte_t	tx_data;		// sender -> uart byte
	wire		tx_req;
	wire		tx_busy;

	word_capture u_capture (
		.SYS_CLK	(SYS_CLK),
		.RST_N		(RST_N),
		.in_req		(in_req),
		.in_ack		(in_ack),
		.in_data	(in_data),
		.wr		(wr_link.requester)
	);

	word_fifo #(
		.FIFO_DEPTH	(FIFO_DEPTH)
	) u_fifo (
		.SYS_CLK	(SYS_CLK),
		.RST_N		(RST_N),
		.wr		(wr_link.responder),
		.rd		(rd_link.responder)
	);

	frame_sender #(
		.FRAME_WORDS	(FRAME_WORDS)
	) u_sender (
		.SYS_CLK	(SYS_CLK),
		.RST_N		(RST_N),
		.rd		(rd_link.requester),
		.tx_data	(tx_data),
		.tx_req		(tx_req),
		.tx_busy	(tx_busy)
	);

	uart_tx #(
		.CLKS_PER_BIT	(CLKS_PER_BIT)
	) u_uart (
		.SYS_CLK	(SYS_CLK),
		.RST_N		(RST_N),
		.tx_req		(tx_req),
		.tx_data	(tx_data),
		.tx_busy	(tx_busy),
		.txd		(txd)
	);

endmodule

`default_nettype wire

//--- testbench/tb_uart_frame.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_frame;
	import uart_frame_pkg::*;

	localparam int		FRAME_WORDS  = 4;
	localparam int		FIFO_DEPTH   = 8;
	localparam int		CLKS_PER_BIT = 8;
	localparam int		NUM_WORDS    = 12;			// more than the fifo holds
	localparam int		FRAME_BYTES  = 4 + 2 * FRAME_WORDS;	// header + payload + trailer
	localparam int		NUM_BYTES    = NUM_WORDS / FRAME_WORDS * FRAME_BYTES;
	localparam int		TIMEOUT      = 6000;			// about twice the whole burst
	localparam int		STALL_MIN    = 2 * CLKS_PER_BIT;	// well above a plain handshake
	localparam byte_t	MODE_BYTE    = 8'h01;

	logic		SYS_CLK;
	logic		RST_N;
	logic		in_req;
	sample_t	in_data;
	wire		in_ack;
	wire		txd;

	integer		seed = 32'h9848;
	sample_t	word_q[$];		// expected words, input order
	byte_t		exp_bytes[$];		// expected serial stream
	int		rx_count;		// bytes decoded so far
	int		cycle_cnt;
	int		stall_cnt;		// current run of in_req high with in_ack low
	int		max_stall;
	logic		reset_window;		// reset plus a few idle cycles after

	uart_frame_top #(
		.FRAME_WORDS	(FRAME_WORDS),
		.FIFO_DEPTH	(FIFO_DEPTH),
		.CLKS_PER_BIT	(CLKS_PER_BIT)
	) u_dut (
		.SYS_CLK	(SYS_CLK),
		.RST_N		(RST_N),
		.in_req		(in_req),
		.in_ack		(in_ack),
		.in_data	(in_data),
		.txd		(txd)
	);

	initial begin
		SYS_CLK = 1'b0;
		forever #20 SYS_CLK = ~SYS_CLK;		// 40 ns period
	end

	task automatic abort_test;
		$display("Test failed");
		$fatal(1, "run stopped on the first failed check");
	endtask

	// header then payload low byte first then trailer for each frame
	task automatic build_expected;
		sample_t	wv;
		int		f;
		int		w;
		for (f = 0; f < NUM_WORDS / FRAME_WORDS; f++) begin
			exp_bytes.push_back(MODE_BYTE);
			exp_bytes.push_back(~MODE_BYTE);
			for (w = 0; w < FRAME_WORDS; w++) begin
				wv = word_q[f * FRAME_WORDS + w];
				exp_bytes.push_back(wv[7:0]);
				exp_bytes.push_back(wv[15:8]);
			end
			exp_bytes.push_back(~MODE_BYTE);
			exp_bytes.push_back(MODE_BYTE);
		end
	endtask

	// four-phase word source entered 2 ns past a rising edge
	task automatic send_word(input sample_t w);
		in_data = w;
		in_req  = 1'b1;
		do begin
			@(posedge SYS_CLK);
			#2;
		end while (!in_ack);
		in_req = 1'b0;
		do begin
			@(posedge SYS_CLK);
			#2;
		end while (in_ack);		// next req only after ack low
	endtask

	//------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------
	initial begin : main_seq
		sample_t	w;
		int		i;
		RST_N        = 1'b1;
		in_req       = 1'b0;
		in_data      = '0;
		reset_window = 1'b1;
		rx_count     = 0;
		for (i = 0; i < NUM_WORDS; i++) begin
			w = sample_t'($random(seed));
			word_q.push_back(w);
		end
		build_expected();
		#1 RST_N = 1'b0;			// real falling edge for the async reset
		repeat (16) @(posedge SYS_CLK);
		#2 RST_N = 1'b1;
		repeat (4) @(posedge SYS_CLK);
		#2 reset_window = 1'b0;
		for (i = 0; i < NUM_WORDS; i++) begin
			send_word(word_q[i]);		// one burst that overflows the fifo
		end
		while (rx_count < NUM_BYTES) begin
			@(posedge SYS_CLK);
		end
		if (max_stall >= STALL_MIN) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("no back-pressure seen, longest in_ack stall was %0d cycles",
				max_stall);
			abort_test();
		end
	end

	// stall tracking and run limit on the quiet edge
	always @(negedge SYS_CLK) begin
		cycle_cnt = cycle_cnt + 1;
		if (in_req && !in_ack) begin
			stall_cnt = stall_cnt + 1;
		end else begin
			stall_cnt = 0;
		end
		if (stall_cnt > max_stall) begin
			max_stall = stall_cnt;
		end
		if (cycle_cnt == TIMEOUT) begin
			$display("timeout after %0d cycles, %0d of %0d bytes received",
				cycle_cnt, rx_count, NUM_BYTES);
			abort_test();
		end
	end

	initial begin
		cycle_cnt = 0;
		stall_cnt = 0;
		max_stall = 0;
	end

	//------------------------------------------------------------
	// serial decoder where every low level on txd must be a full byte
	//------------------------------------------------------------
	initial begin : serial_decoder
		byte_t	rx;
		byte_t	exp;
		int	b;
		forever begin
			@(negedge SYS_CLK);
			if (RST_N && !txd) begin
				repeat (CLKS_PER_BIT / 2) @(negedge SYS_CLK);	// middle of start bit
				assert (txd == 1'b0) else begin
					$display("Error: %0t ns, signal txd start bit, expected 0, actual %b",
						$time, txd);
					abort_test();
				end
				for (b = 0; b < 8; b++) begin
					repeat (CLKS_PER_BIT) @(negedge SYS_CLK);
					rx = {txd, rx[7:1]};		// lsb first
				end
				repeat (CLKS_PER_BIT) @(negedge SYS_CLK);
				assert (txd == 1'b1) else begin
					$display("Error: %0t ns, signal txd stop bit, expected 1, actual %b",
						$time, txd);
					abort_test();
				end
				repeat (CLKS_PER_BIT / 2 - 1) begin	// rest of the stop bit
					@(negedge SYS_CLK);
					assert (txd == 1'b1) else begin
						$display("Error: %0t ns, signal txd stop tail, expected 1, actual %b",
							$time, txd);
						abort_test();
					end
				end
				if (exp_bytes.size() == 0) begin
					$display("byte 0x%02h received after the last expected byte", rx);
					abort_test();
				end else begin
					exp = exp_bytes.pop_front();
					assert (rx == exp) else begin
						$display("Error: %0t ns, signal txd byte %0d, expected 0x%02h, actual 0x%02h",
							$time, rx_count, exp, rx);
						abort_test();
					end
					rx_count = rx_count + 1;
				end
			end
		end
	end

	//------------------------------------------------------------
	// port checks
	//------------------------------------------------------------
	a_reset_txd: assert property (@(negedge SYS_CLK) reset_window |-> (txd === 1'b1))
		else begin
			$display("Error: %0t ns, signal txd, expected 1, actual %b", $time, txd);
			abort_test();
		end

	a_reset_in_ack: assert property (@(negedge SYS_CLK) reset_window |-> (in_ack === 1'b0))
		else begin
			$display("Error: %0t ns, signal in_ack, expected 0, actual %b", $time, in_ack);
			abort_test();
		end

	// source drops in_req right after it sees in_ack, so look one cycle back
	a_ack_needs_req: assert property (@(negedge SYS_CLK) disable iff (!RST_N)
		$rose(in_ack) |-> $past(in_req))
		else begin
			$display("in_ack rose at %0t ns while in_req was low", $time);
			abort_test();
		end

	// in_ack drops only once in_req is gone
	a_ack_drop: assert property (@(negedge SYS_CLK) disable iff (!RST_N)
		$fell(in_ack) |-> !$past(in_req))
		else begin
			$display("in_ack fell at %0t ns while in_req was still high", $time);
			abort_test();
		end

endmodule

`default_nettype wire

//--- filelist.f
src/uart_frame_pkg.sv
src/word_if.sv
src/word_capture.sv
src/word_fifo.sv
src/frame_sender.sv
src/uart_tx.sv
src/uart_frame_top.sv
testbench/tb_uart_frame.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status follows the run
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_uart_frame \
	-o sim_tb \
	&& ./obj_dir/sim_tb \
	|| { echo "simulation run returned an error status"; exit 1; }

exit 0
